// File: project.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_core.sv
cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module cpu_tb -f project.f -o cpu_tb_sim \
	&& ./obj_dir/cpu_tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log && { echo "PASS"; exit 0; } \
	|| { echo "FAIL: no result in log"; exit 1; }

// File: cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_tb;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int PROG_LEN = 200;
	localparam int LAST_PC = PROG_LEN - 1;
	localparam int ROM_WORDS = 2 ** `IMEM_ADDR_WIDTH;
	localparam int DMEM_WORDS = 2 ** `DMEM_ADDR_WIDTH;

	logic clk;
	logic rst_n;
	pc_t imem_addr;
	word_t imem_data;
	reg_write_t reg_write;
	store_t store;

	word_t rom [ROM_WORDS];
	pc_t rom_addr;
	logic [31:0] rng_state = 32'hbd81;
	int model_count;
	int cycle_limit;

	// expected port traffic in arrival order
	reg_write_t exp_writes [$];
	store_t exp_stores [$];

	cpu_core cpu_core_i (
		.clk(clk),
		.rst_n(rst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.reg_write(reg_write),
		.store(store)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	////////////////////
	// program generator
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic word_t encode_reg(opcode_e op, reg_addr_t rd, reg_addr_t rs1,
		reg_addr_t rs2);
		return {op, rd, rs1, rs2, 12'h000};
	endfunction

	function automatic word_t encode_imm(opcode_e op, reg_addr_t rd, reg_addr_t rs1,
		logic [15:0] imm);
		return {op, rd, rs1, 1'b0, imm};
	endfunction

	task automatic build_program();
		opcode_e reg_ops [8];
		opcode_e imm_ops [3];
		logic [31:0] r;
		logic [15:0] off;
		reg_addr_t base;
		reg_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
		imm_ops = '{OP_ADDI, OP_ANDI, OP_ORI};
		// filler is a no-op that carries its own address
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = {5'd31, 16'h0000, pc_t'(i)};
		end
		for (int i = 0; i < LAST_PC; i++) begin
			r = next_random();
			// small register pool keeps dependencies close together
			base = r[20] ? 5'd0 : {2'b00, r[12:10]};
			off = {13'h0000, r[18:16]};
			case (r[3:0])
				4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: rom[i] = encode_reg(reg_ops[r[6:4]],
					{2'b00, r[9:7]}, {2'b00, r[12:10]}, {2'b00, r[15:13]});
				4'd6, 4'd7, 4'd8: rom[i] = encode_imm(imm_ops[r[5:4] % 2'd3],
					{2'b00, r[9:7]}, {2'b00, r[12:10]}, r[31:16]);
				4'd9: rom[i] = encode_imm(OP_LW, {2'b00, r[9:7]}, 5'd0, {12'h000, r[19:16]});
				4'd10: rom[i] = encode_imm(OP_SW, {2'b00, r[9:7]}, 5'd0, {12'h000, r[19:16]});
				4'd11: rom[i] = encode_imm(OP_LWO, {2'b00, r[9:7]}, base, {12'h000, r[19:16]});
				4'd12: rom[i] = encode_imm(OP_SWO, {2'b00, r[9:7]}, base, {12'h000, r[19:16]});
				4'd13, 4'd14: begin
					// forward only and never past the final self loop
					if (i + 1 + int'(off) > LAST_PC) begin
						off = 16'(LAST_PC - i - 1);
					end
					rom[i] = encode_imm(OP_B, {r[6:4], 2'b00}, 5'd0, off);
				end
				default: rom[i] = {(r[4] ? 5'd12 : 5'd25), 27'h0000000};
			endcase
		end
		rom[LAST_PC] = encode_imm(OP_B, {COND_ALWAYS, 2'b00}, 5'd0, 16'hffff);
	endtask

	////////////////////
	// reference model
	////////////////////

	function automatic logic cond_holds(logic [2:0] cond, flags_t f);
		case (cond)
			COND_NE: return !f.zero;
			COND_EQ: return f.zero;
			COND_GT: return !f.zero && !f.sign;
			COND_LT: return f.sign;
			COND_GE: return !f.sign;
			COND_LE: return f.sign || f.zero;
			COND_OVER: return f.overflow;
			default: return 1'b1;
		endcase
	endfunction

	function automatic word_t alu_model(logic [4:0] op, word_t a, word_t b, output flags_t f);
		logic [32:0] wide;
		word_t res;
		f.overflow = 1'b0;
		case (op)
			OP_ADD, OP_ADDI: begin
				// signed overflow when the 33-bit sum leaves 32-bit range
				wide = {a[31], a} + {b[31], b};
				res = wide[31:0];
				f.overflow = wide[32] != wide[31];
			end
			OP_SUB: begin
				wide = {a[31], a} - {b[31], b};
				res = wide[31:0];
				f.overflow = wide[32] != wide[31];
			end
			OP_AND, OP_ANDI: res = a & b;
			OP_OR, OP_ORI: res = a | b;
			OP_XOR: res = a ^ b;
			OP_SLL: res = a << b[4:0];
			OP_SRL: res = a >> b[4:0];
			default: begin
				// arithmetic shift fills the vacated top bits with the sign
				res = a >> b[4:0];
				if (a[31]) begin
					res = res | ~(32'hffff_ffff >> b[4:0]);
				end
			end
		endcase
		f.zero = (res == '0);
		f.sign = res[31];
		return res;
	endfunction

	task automatic run_model();
		word_t regs [`REG_COUNT];
		word_t mem [DMEM_WORDS];
		flags_t flags;
		int pc;
		int next_pc;
		word_t ins;
		logic [4:0] op;
		reg_addr_t rd;
		word_t a;
		word_t imm;
		word_t value;
		dmem_addr_t addr;
		logic writes;
		logic stores;
		reg_write_t w;
		store_t s;
		for (int i = 0; i < `REG_COUNT; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			mem[i] = '0;
		end
		flags = '0;
		pc = 0;
		model_count = 0;
		while (pc != LAST_PC) begin
			ins = rom[pc];
			op = ins[31:27];
			rd = ins[26:22];
			a = regs[ins[21:17]];
			imm = word_t'($signed(ins[15:0]));
			next_pc = pc + 1;
			writes = 1'b0;
			stores = 1'b0;
			value = '0;
			addr = '0;
			model_count++;
			case (op)
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
					value = alu_model(op, a, regs[ins[16:12]], flags);
					writes = 1'b1;
				end
				OP_ADDI, OP_ANDI, OP_ORI: begin
					value = alu_model(op, a, imm, flags);
					writes = 1'b1;
				end
				OP_LW, OP_LWO: begin
					addr = (op == OP_LW) ? dmem_addr_t'(imm) : dmem_addr_t'(a + imm);
					value = mem[addr];
					writes = 1'b1;
				end
				OP_SW, OP_SWO: begin
					addr = (op == OP_SW) ? dmem_addr_t'(imm) : dmem_addr_t'(a + imm);
					stores = 1'b1;
				end
				OP_B: begin
					if (cond_holds(ins[26:24], flags)) begin
						next_pc = (pc + 1 + int'(ins[10:0])) % ROM_WORDS;
					end
				end
				default: ;
			endcase
			if (writes) begin
				w.valid = 1'b1;
				w.dest = rd;
				w.data = value;
				exp_writes.push_back(w);
				// r0 shows on the port but keeps its zero
				if (rd != '0) begin
					regs[rd] = value;
				end
			end
			if (stores) begin
				s.valid = 1'b1;
				s.addr = addr;
				s.data = regs[rd];
				exp_stores.push_back(s);
				mem[addr] = regs[rd];
			end
			pc = next_pc;
		end
		// the final self loop
		model_count++;
	endtask

	////////////////////
	// checks
	////////////////////

	task automatic check_reg_write(input reg_write_t got);
		reg_write_t exp;
		if (exp_writes.size() == 0) begin
			report_failure("a register write arrived after all expected writes");
		end else begin
			exp = exp_writes.pop_front();
			if (got.dest !== exp.dest || got.data !== exp.data) begin
				report_failure($sformatf("ERROR %0t: write r%0d = %h, expected r%0d = %h",
					$time, got.dest, got.data, exp.dest, exp.data));
			end
		end
	endtask

	task automatic check_store(input store_t got);
		store_t exp;
		if (exp_stores.size() == 0) begin
			report_failure("a store arrived after all expected stores");
		end else begin
			exp = exp_stores.pop_front();
			if (got.addr !== exp.addr || got.data !== exp.data) begin
				report_failure($sformatf("ERROR %0t: store [%h] = %h, expected [%h] = %h",
					$time, got.addr, got.data, exp.addr, exp.data));
			end
		end
	endtask

	// synchronous ROM sampling its address mid-cycle
	initial begin
		forever begin
			@(negedge clk);
			rom_addr = imem_addr;
			@(posedge clk);
			#5;
			imem_data = rom[rom_addr];
		end
	end

	// port monitor
	initial begin
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				if (reg_write.valid || store.valid) begin
					report_failure("a valid strobe was raised during reset");
				end
			end else begin
				if (reg_write.valid) begin
					check_reg_write(reg_write);
				end
				if (store.valid) begin
					check_store(store);
				end
			end
		end
	end

	// watchdog
	initial begin
		wait (cycle_limit != 0);
		repeat (cycle_limit) @(posedge clk);
		report_failure($sformatf("timeout after %0d cycles, the expected writes did not all arrive",
			cycle_limit));
	end

	initial begin
		rst_n = 1'b0;
		imem_data = '0;
		build_program();
		run_model();
		$display("model retires %0d instructions, %0d writes, %0d stores",
			model_count, exp_writes.size(), exp_stores.size());
		cycle_limit = 4 * model_count + 200;
		repeat (8) @(posedge clk);
		#5;
		rst_n = 1'b1;
		while (exp_writes.size() != 0 || exp_stores.size() != 0) begin
			@(posedge clk);
		end
		// nothing more may come out once the program sits in its loop
		repeat (20) @(posedge clk);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input wire clk,
	input wire rst_n,
	output isa_pkg::pc_t imem_addr,
	input wire isa_pkg::word_t imem_data,
	output pipe_pkg::reg_write_t reg_write,
	output pipe_pkg::store_t store
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// IF/ID and fetch control
	word_t instr;
	pc_t instr_pc;
	logic instr_valid;
	logic redirect;
	pc_t redirect_pc;
	logic stall;

	// later stages
	idex_t idex;
	exmem_t exmem;
	logic flag_update;
	flags_t next_flags;

	fetch_stage fetch_stage_i (
		.clk(clk),
		.rst_n(rst_n),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.stall(stall),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_valid(instr_valid)
	);

	decode_stage decode_stage_i (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_valid(instr_valid),
		.flag_update(flag_update),
		.next_flags(next_flags),
		.wb(reg_write),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.stall(stall),
		.idex(idex)
	);

	execute_stage execute_stage_i (
		.clk(clk),
		.rst_n(rst_n),
		.idex(idex),
		.wb(reg_write),
		.exmem(exmem),
		.flag_update(flag_update),
		.next_flags(next_flags)
	);

	// write-back is the MEM/WB output itself
	memory_stage memory_stage_i (
		.clk(clk),
		.rst_n(rst_n),
		.exmem(exmem),
		.wb(reg_write),
		.store(store)
	);

endmodule

`default_nettype wire

// File: memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module memory_stage (
	input wire clk,
	input wire rst_n,
	input wire pipe_pkg::exmem_t exmem,
	output pipe_pkg::reg_write_t wb,
	output pipe_pkg::store_t store
);
	import isa_pkg::*;

	localparam int DMEM_WORDS = 2 ** `DMEM_ADDR_WIDTH;

	word_t dmem [DMEM_WORDS];
	dmem_addr_t addr;
	word_t store_data;
	word_t mem_result;

	assign addr = exmem.result[`DMEM_ADDR_WIDTH-1:0];

	// a load right before the store may own the data register
	assign store_data = (wb.valid && wb.dest != '0 && wb.dest == exmem.store_source) ?
		wb.data : exmem.store_data;

	assign store.valid = exmem.valid && exmem.mem.write;
	assign store.addr = addr;
	assign store.data = store_data;

	////////////////////
	// data memory
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (store.valid) begin
			dmem[addr] <= store_data;
		end
	end

	assign mem_result = exmem.mem.read ? dmem[addr] : exmem.result;

	////////////////////
	// MEM/WB register
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb.valid <= exmem.valid && exmem.wb.write_reg;
			wb.dest <= exmem.wb.dest;
			wb.data <= mem_result;
		end
	end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input wire clk,
	input wire rst_n,
	input wire pipe_pkg::idex_t idex,
	input wire pipe_pkg::reg_write_t wb,
	output pipe_pkg::exmem_t exmem,
	output logic flag_update,
	output isa_pkg::flags_t next_flags
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int MSB = $bits(word_t) - 1;
	localparam int SHAMT_WIDTH = $clog2($bits(word_t));

	fwd_src_e sel_a;
	fwd_src_e sel_b;
	word_t op_a;
	word_t reg_b;
	word_t op_b;
	word_t alu_out;
	word_t result;
	logic overflow;

	// newest writer wins, EX/MEM before MEM/WB
	function automatic fwd_src_e fwd_select(reg_addr_t src, exmem_t em, reg_write_t w);
		fwd_src_e sel;
		sel = FWD_REG;
		if (w.valid && w.dest != '0 && w.dest == src) begin
			sel = FWD_MEMWB;
		end
		if (em.valid && em.wb.write_reg && em.wb.dest != '0 && em.wb.dest == src) begin
			sel = FWD_EXMEM;
		end
		return sel;
	endfunction

	function automatic word_t fwd_value(fwd_src_e sel, word_t reg_val, word_t em_val,
		word_t w_val);
		case (sel)
			FWD_EXMEM: return em_val;
			FWD_MEMWB: return w_val;
			default: return reg_val;
		endcase
	endfunction

	assign sel_a = fwd_select(idex.src1, exmem, wb);
	assign sel_b = fwd_select(idex.src2, exmem, wb);
	assign op_a = fwd_value(sel_a, idex.op1, exmem.result, wb.data);
	assign reg_b = fwd_value(sel_b, idex.op2, exmem.result, wb.data);
	assign op_b = idex.ex.use_immediate ? idex.immediate : reg_b;

	////////////////////
	// ALU
	////////////////////

	always_comb begin
		alu_out = '0;
		overflow = 1'b0;
		case (idex.ex.alu_op)
			ALU_ADD: begin
				alu_out = op_a + op_b;
				overflow = (op_a[MSB] == op_b[MSB]) && (alu_out[MSB] != op_a[MSB]);
			end
			ALU_SUB: begin
				alu_out = op_a - op_b;
				overflow = (op_a[MSB] != op_b[MSB]) && (alu_out[MSB] != op_a[MSB]);
			end
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR: alu_out = op_a | op_b;
			ALU_XOR: alu_out = op_a ^ op_b;
			ALU_SLL: alu_out = op_a << op_b[SHAMT_WIDTH-1:0];
			ALU_SRL: alu_out = op_a >> op_b[SHAMT_WIDTH-1:0];
			ALU_SRA: alu_out = word_t'($signed(op_a) >>> op_b[SHAMT_WIDTH-1:0]);
			default: alu_out = '0;
		endcase
	end

	// lw and sw take the immediate as absolute address
	assign result = idex.ex.select_immediate ? idex.immediate : alu_out;

	assign next_flags.zero = (alu_out == '0);
	assign next_flags.sign = alu_out[MSB];
	assign next_flags.overflow = overflow;
	assign flag_update = idex.valid && idex.ex.update_flags;

	////////////////////
	// EX/MEM register
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exmem <= '0;
		end else begin
			exmem.valid <= idex.valid;
			exmem.result <= result;
			exmem.store_data <= reg_b;
			exmem.store_source <= idex.src2;
			exmem.mem <= idex.mem;
			exmem.wb <= idex.wb;
		end
	end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decode_stage (
	input wire clk,
	input wire rst_n,
	input wire isa_pkg::word_t instr,
	input wire isa_pkg::pc_t instr_pc,
	input wire instr_valid,
	input wire flag_update,
	input wire isa_pkg::flags_t next_flags,
	input wire pipe_pkg::reg_write_t wb,
	output logic redirect,
	output isa_pkg::pc_t redirect_pc,
	output logic stall,
	output pipe_pkg::idex_t idex
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_e opcode;
	branch_cond_e cond;
	ex_ctrl_t ex_ctrl;
	mem_ctrl_t mem_ctrl;
	wb_ctrl_t wb_ctrl;
	logic issues;
	logic is_branch;
	logic is_store;
	logic reads_src1;
	logic reads_src2;
	reg_addr_t src1;
	reg_addr_t src2;
	word_t immediate;
	word_t op1;
	word_t op2;
	word_t rf [`REG_COUNT];
	flags_t flags;
	logic take;
	logic load_use;
	logic flag_hazard;

	assign opcode = opcode_e'(instr[31:27]);
	assign cond = branch_cond_e'(instr[26:24]);
	assign immediate = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};

	////////////////////
	// decoder
	////////////////////

	always_comb begin
		ex_ctrl = '0;
		mem_ctrl = '0;
		wb_ctrl = '0;
		wb_ctrl.dest = instr[26:22];
		issues = 1'b1;
		is_branch = 1'b0;
		is_store = 1'b0;
		reads_src1 = 1'b0;
		reads_src2 = 1'b0;

		case (opcode)
			OP_SUB: ex_ctrl.alu_op = ALU_SUB;
			OP_AND, OP_ANDI: ex_ctrl.alu_op = ALU_AND;
			OP_OR, OP_ORI: ex_ctrl.alu_op = ALU_OR;
			OP_XOR: ex_ctrl.alu_op = ALU_XOR;
			OP_SLL: ex_ctrl.alu_op = ALU_SLL;
			OP_SRL: ex_ctrl.alu_op = ALU_SRL;
			OP_SRA: ex_ctrl.alu_op = ALU_SRA;
			// add, and the offset address of lwo and swo
			default: ex_ctrl.alu_op = ALU_ADD;
		endcase

		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
				ex_ctrl.update_flags = 1'b1;
				wb_ctrl.write_reg = 1'b1;
				reads_src1 = 1'b1;
				reads_src2 = 1'b1;
			end
			OP_ADDI, OP_ANDI, OP_ORI: begin
				ex_ctrl.update_flags = 1'b1;
				ex_ctrl.use_immediate = 1'b1;
				wb_ctrl.write_reg = 1'b1;
				reads_src1 = 1'b1;
			end
			OP_LW: begin
				ex_ctrl.select_immediate = 1'b1;
				mem_ctrl.read = 1'b1;
				wb_ctrl.write_reg = 1'b1;
			end
			OP_SW: begin
				ex_ctrl.select_immediate = 1'b1;
				mem_ctrl.write = 1'b1;
				is_store = 1'b1;
			end
			OP_LWO: begin
				ex_ctrl.use_immediate = 1'b1;
				mem_ctrl.read = 1'b1;
				wb_ctrl.write_reg = 1'b1;
				reads_src1 = 1'b1;
			end
			OP_SWO: begin
				ex_ctrl.use_immediate = 1'b1;
				mem_ctrl.write = 1'b1;
				is_store = 1'b1;
				reads_src1 = 1'b1;
			end
			OP_B: begin
				// resolved here, nothing goes down the pipe
				is_branch = 1'b1;
				issues = 1'b0;
			end
			default: issues = 1'b0;
		endcase
	end

	// stores carry their data register in the destination field
	assign src1 = instr[21:17];
	assign src2 = is_store ? instr[26:22] : instr[16:12];

	////////////////////
	// register file
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				rf[i] <= '0;
			end
		end else if (wb.valid && wb.dest != '0) begin
			rf[wb.dest] <= wb.data;
		end
	end

	// write-through from the instruction in write-back
	always_comb begin
		op1 = rf[src1];
		op2 = rf[src2];
		if (wb.valid && wb.dest != '0 && wb.dest == src1) begin
			op1 = wb.data;
		end
		if (wb.valid && wb.dest != '0 && wb.dest == src2) begin
			op2 = wb.data;
		end
	end

	////////////////////
	// flags and branches
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (flag_update) begin
			flags <= next_flags;
		end
	end

	always_comb begin
		take = 1'b0;
		case (cond)
			COND_NE: take = ~flags.zero;
			COND_EQ: take = flags.zero;
			COND_GT: take = ~flags.zero & ~flags.sign;
			COND_LT: take = ~flags.zero & flags.sign;
			COND_GE: take = flags.zero | ~flags.sign;
			COND_LE: take = flags.zero | flags.sign;
			COND_OVER: take = flags.overflow;
			COND_ALWAYS: take = 1'b1;
			default: take = 1'b0;
		endcase
	end

	assign redirect_pc = instr_pc + pc_t'(1) + immediate[`IMEM_ADDR_WIDTH-1:0];
	assign redirect = instr_valid && is_branch && take && !stall;

	////////////////////
	// hazards
	////////////////////

	// store data after a load is fixed up in memory, so only ALU operands count
	assign load_use = idex.valid && idex.mem.read && idex.wb.dest != '0 &&
		((reads_src1 && idex.wb.dest == src1) || (reads_src2 && idex.wb.dest == src2));

	// flags from the instruction in execute are not written yet
	assign flag_hazard = is_branch && idex.valid && idex.ex.update_flags;

	assign stall = instr_valid && (load_use || flag_hazard);

	////////////////////
	// ID/EX register
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idex <= '0;
		end else if (!instr_valid || stall || !issues) begin
			idex <= '0;
		end else begin
			idex.valid <= 1'b1;
			idex.op1 <= op1;
			idex.op2 <= op2;
			idex.immediate <= immediate;
			idex.src1 <= src1;
			idex.src2 <= src2;
			idex.ex <= ex_ctrl;
			idex.mem <= mem_ctrl;
			idex.wb <= wb_ctrl;
		end
	end

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input wire clk,
	input wire rst_n,
	input wire redirect,
	input wire isa_pkg::pc_t redirect_pc,
	input wire stall,
	output isa_pkg::pc_t imem_addr,
	input wire isa_pkg::word_t imem_data,
	output isa_pkg::word_t instr,
	output isa_pkg::pc_t instr_pc,
	output logic instr_valid
);
	import isa_pkg::*;

	logic pc_reset;
	pc_t pc_held;

	// first cycle out of reset fetches address 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_reset <= 1'b1;
		end else begin
			pc_reset <= 1'b0;
		end
	end

	// address whose word the ROM is returning now
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_held <= '0;
		end else begin
			pc_held <= imem_addr;
		end
	end

	always_comb begin
		if (pc_reset) begin
			imem_addr = '0;
		end else if (redirect) begin
			imem_addr = redirect_pc;
		end else if (stall) begin
			imem_addr = pc_held;
		end else begin
			imem_addr = pc_held + pc_t'(1);
		end
	end

	////////////////////
	// IF/ID register
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_valid <= 1'b0;
			instr <= '0;
			instr_pc <= '0;
		end else if (redirect) begin
			// slot behind a taken branch
			instr_valid <= 1'b0;
		end else if (!stall) begin
			// ROM output is undefined while pc_reset is high
			instr_valid <= ~pc_reset;
			instr <= imem_data;
			instr_pc <= pc_held;
		end
	end

endmodule

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	import isa_pkg::*;

	// per-stage control, set up by the decoder
	typedef struct packed {
		alu_op_e alu_op;
		logic use_immediate;
		logic select_immediate;
		logic update_flags;
	} ex_ctrl_t;

	typedef struct packed {
		logic read;
		logic write;
	} mem_ctrl_t;

	typedef struct packed {
		reg_addr_t dest;
		logic write_reg;
	} wb_ctrl_t;

	////////////////////
	// stage registers
	////////////////////

	typedef struct packed {
		logic valid;
		word_t op1;
		word_t op2;
		word_t immediate;
		reg_addr_t src1;
		reg_addr_t src2;
		ex_ctrl_t ex;
		mem_ctrl_t mem;
		wb_ctrl_t wb;
	} idex_t;

	typedef struct packed {
		logic valid;
		word_t result;
		word_t store_data;
		reg_addr_t store_source;
		mem_ctrl_t mem;
		wb_ctrl_t wb;
	} exmem_t;

	// operand source picked by the forwarding unit
	typedef enum logic [1:0] {
		FWD_REG, FWD_EXMEM, FWD_MEMWB
	} fwd_src_e;

	// MEM/WB output, also the register write port
	typedef struct packed {
		logic valid;
		reg_addr_t dest;
		word_t data;
	} reg_write_t;

	typedef struct packed {
		logic valid;
		dmem_addr_t addr;
		word_t data;
	} store_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package isa_pkg;

	// widths with a meaning
	typedef logic [`DATA_WIDTH-1:0] word_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [`IMEM_ADDR_WIDTH-1:0] pc_t;
	typedef logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

	// opcodes, bits 31 to 27 of an instruction
	// gaps and codes above b decode as no-ops
	typedef enum logic [4:0] {
		OP_ADD  = 5'd0,
		OP_ADDI = 5'd1,
		OP_SUB  = 5'd2,
		OP_AND  = 5'd3,
		OP_ANDI = 5'd4,
		OP_OR   = 5'd5,
		OP_ORI  = 5'd6,
		OP_XOR  = 5'd7,
		OP_SLL  = 5'd8,
		OP_SRL  = 5'd9,
		OP_SRA  = 5'd10,
		OP_LW   = 5'd13,
		OP_SW   = 5'd14,
		OP_LWO  = 5'd15,
		OP_SWO  = 5'd16,
		OP_B    = 5'd17
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	// branch condition, bits 26 to 24 of a b instruction
	typedef enum logic [2:0] {
		COND_NE, COND_EQ, COND_GT, COND_LT, COND_GE, COND_LE, COND_OVER, COND_ALWAYS
	} branch_cond_e;

	typedef struct packed {
		logic zero;
		logic sign;
		logic overflow;
	} flags_t;

endpackage

`default_nettype wire

// File: cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// word and register file geometry
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// instruction memory, counted in words
`define IMEM_ADDR_WIDTH 11

// data memory, counted in words
`define DMEM_ADDR_WIDTH 8

`endif
